//--- sources.f
src/core_pkg.sv
src/mem_pkg.sv
src/lsq_queue.sv
src/load_tracker.sv
src/lsq_top.sv
sim/tb_clock.sv
sim/lsq_tb.sv

//--- Bender.yml
package:
  name: lsq

sources:
  - src/core_pkg.sv
  - src/mem_pkg.sv
  - src/lsq_queue.sv
  - src/load_tracker.sv
  - src/lsq_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/lsq_tb.sv

//--- sim/lsq_tb.sv
`timescale 1ns/1ns

module lsq_tb;

    localparam int depth = 8;
    localparam int period_ns = 40;
    // 180 operations over all tests, none should need more than 100 cycles
    localparam longint timeout_ns = longint'(180 * 100 + 400) * period_ns;

    // reference copy of one queued instruction and what it has collected
    typedef struct packed {
        logic               is_store;
        core_pkg::rob_tag_t rob_tag;
        core_pkg::rob_tag_t data_tag;
        logic [31:0]        addr;
        logic [31:0]        value;
        logic               addr_v;
        logic               data_v;
        logic               ret;
    } model_entry_t;

    logic clk;
    logic reset;
    core_pkg::issue_pkt_t  issue_in;
    core_pkg::addr_pkt_t   addr_in;
    core_pkg::cdb_pkt_t    cdb_in;
    core_pkg::retire_pkt_t retire_in;
    mem_pkg::dcache_resp_t dcache_resp_in;
    mem_pkg::mem_return_t  mem_return_in;
    mem_pkg::dcache_req_t  dcache_req;
    core_pkg::cdb_pkt_t    cdb_out;
    logic                  store_ready;
    core_pkg::rob_tag_t    store_ready_tag;
    logic                  stall_dispatch;

    model_entry_t       mq[$];
    logic               pend_valid [16];
    core_pkg::rob_tag_t pend_rob [16];
    // what cdb_out must show after the coming edge
    core_pkg::cdb_pkt_t exp_cdb;
    int op_count;
    int check_count;
    int error_count;

    tb_clock #(.period_ns(period_ns)) clock_i (.clk(clk));

    lsq_top #(.lsq_depth(depth)) dut_i (
        .clk(clk), .reset(reset), .issue_in(issue_in), .addr_in(addr_in),
        .cdb_in(cdb_in), .retire_in(retire_in), .dcache_resp_in(dcache_resp_in),
        .mem_return_in(mem_return_in), .dcache_req(dcache_req), .cdb_out(cdb_out),
        .store_ready(store_ready), .store_ready_tag(store_ready_tag),
        .stall_dispatch(stall_dispatch)
    );

    task automatic check_req(mem_pkg::dcache_req_t act, mem_pkg::dcache_req_t exp);
        check_count++;
        // address only matters with a command, data only for stores
        if (act.command !== exp.command || (exp.command != mem_pkg::bus_none
            && act.address !== exp.address) || (exp.command == mem_pkg::bus_store
            && act.data !== exp.data)) begin
            error_count++;
            $display("FAILED dcache_req: got %h expected %h", act, exp);
        end
    endtask

    task automatic check_cdb(core_pkg::cdb_pkt_t act, core_pkg::cdb_pkt_t exp);
        check_count++;
        if (act.valid !== exp.valid || (exp.valid && (act.tag !== exp.tag
            || act.value !== exp.value))) begin
            error_count++;
            $display("FAILED cdb_out: got %h expected %h", act, exp);
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_tag(string name, core_pkg::rob_tag_t act, core_pkg::rob_tag_t exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s: got %h expected %h", name, act, exp);
        end
    endtask

    // random queued entry still missing address (0), store data (1) or retire (2)
    function automatic int pick_waiting(int kind);
        int cand[$];
        for (int i = 0; i < mq.size(); i++) begin
            if ((kind == 0 && !mq[i].addr_v) || (kind == 1 && mq[i].is_store && !mq[i].data_v)
                || (kind == 2 && mq[i].is_store && !mq[i].ret))
                cand.push_back(i);
        end
        return (cand.size() == 0) ? -1 : cand[$urandom % cand.size()];
    endfunction

    // random cache tag that is pending or free, zero when there is none
    function automatic mem_pkg::mem_tag_t pick_tag(logic want_pending);
        mem_pkg::mem_tag_t cand[$];
        for (int t = 1; t < 16; t++) begin
            if (pend_valid[t] == want_pending)
                cand.push_back(mem_pkg::mem_tag_t'(t));
        end
        return (cand.size() == 0) ? '0 : cand[$urandom % cand.size()];
    endfunction

    // head request as the queue rules define it
    function automatic mem_pkg::dcache_req_t expected_req(mem_pkg::mem_tag_t ret_tag);
        mem_pkg::dcache_req_t r;
        r = '0;
        if (mq.size() != 0 && !mq[0].is_store && mq[0].addr_v && ret_tag == '0) begin
            r.command = mem_pkg::bus_load;
            r.address = mq[0].addr;
        end else if (mq.size() != 0 && mq[0].is_store && mq[0].addr_v && mq[0].data_v
                     && mq[0].ret) begin
            r.command = mem_pkg::bus_store;
            r.address = mq[0].addr;
            r.data    = {32'h0, mq[0].value};
        end
        return r;
    endfunction

    task automatic run_traffic(string name, int n_ops, int store_pct, int hit_pct,
                               int accept_pct, int wake_pct, int issue_pct, bit need_full);
        int issued;
        int errors_before;
        int checks_before;
        int wake [3];
        bit have_op;
        bit saw_full;
        bit took_issue;
        bit consumed;
        model_entry_t next_op;
        mem_pkg::dcache_req_t exp_req;
        mem_pkg::mem_tag_t ret_tag;
        mem_pkg::mem_tag_t tag;
        errors_before = error_count;
        checks_before = check_count;
        issued = 0;
        have_op = 0;
        saw_full = 0;
        while (issued < n_ops || mq.size() != 0 || pick_tag(1'b1) != '0 || exp_cdb.valid) begin
            @(negedge clk);
            // the next instruction in program order stays offered until taken
            if (!have_op && issued < n_ops) begin
                next_op = '0;
                next_op.is_store = ($urandom % 100) < store_pct;
                next_op.rob_tag  = core_pkg::rob_tag_t'(op_count);
                next_op.data_tag = next_op.rob_tag ^ 5'h10;
                next_op.addr     = $urandom;
                next_op.value    = $urandom;
                have_op = 1'b1;
            end
            issue_in = '0;
            if (have_op && ($urandom % 100) < issue_pct)
                issue_in = '{1'b1, next_op.is_store, next_op.rob_tag, next_op.data_tag};
            addr_in = '0;
            cdb_in = '0;
            retire_in = '0;
            for (int k = 0; k < 3; k++)
                wake[k] = (($urandom % 100) < wake_pct) ? pick_waiting(k) : -1;
            if (wake[0] >= 0)
                addr_in = '{1'b1, mq[wake[0]].rob_tag, mq[wake[0]].addr};
            if (wake[1] >= 0)
                cdb_in = '{1'b1, mq[wake[1]].data_tag, mq[wake[1]].value};
            if (wake[2] >= 0)
                retire_in = '{1'b1, mq[wake[2]].rob_tag};
            // cache stand-in returns a random outstanding miss
            mem_return_in = '0;
            if (($urandom % 100) < 30)
                mem_return_in = '{pick_tag(1'b1), {$urandom, $urandom}};
            ret_tag = mem_return_in.tag;
            exp_req = expected_req(ret_tag);
            dcache_resp_in = '0;
            consumed = 0;
            if (exp_req.command == mem_pkg::bus_load) begin
                if (($urandom % 100) < hit_pct) begin
                    dcache_resp_in.hit = 1'b1;
                    dcache_resp_in.hit_data = {$urandom, $urandom};
                    consumed = 1;
                end else if (($urandom % 100) < accept_pct) begin
                    tag = pick_tag(1'b0);
                    dcache_resp_in.accept_tag = tag;
                    consumed = (tag != '0);
                end
            end else if (exp_req.command == mem_pkg::bus_store
                         && ($urandom % 100) < accept_pct) begin
                dcache_resp_in.accept_tag = mem_pkg::mem_tag_t'(1 + $urandom % 15);
                consumed = 1;
            end
            #1;
            check_cdb(cdb_out, exp_cdb);
            check_req(dcache_req, exp_req);
            check_bit("stall_dispatch", stall_dispatch, mq.size() == depth);
            check_bit("store_ready", store_ready, exp_req.command == mem_pkg::bus_store);
            if (exp_req.command == mem_pkg::bus_store)
                check_tag("store_ready_tag", store_ready_tag, mq[0].rob_tag);
            saw_full |= (mq.size() == depth);
            // bus result due after the edge, a return has priority by construction
            exp_cdb = '0;
            if (ret_tag != '0) begin
                exp_cdb = '{1'b1, pend_rob[ret_tag], mem_return_in.data[31:0]};
                pend_valid[ret_tag] = 1'b0;
            end else if (dcache_resp_in.hit) begin
                exp_cdb = '{1'b1, mq[0].rob_tag, dcache_resp_in.hit_data[31:0]};
            end
            if (consumed && exp_req.command == mem_pkg::bus_load && !dcache_resp_in.hit) begin
                pend_valid[dcache_resp_in.accept_tag] = 1'b1;
                pend_rob[dcache_resp_in.accept_tag] = mq[0].rob_tag;
            end
            // wakeups land at the edge, full is judged before the pop
            if (wake[0] >= 0) mq[wake[0]].addr_v = 1'b1;
            if (wake[1] >= 0) mq[wake[1]].data_v = 1'b1;
            if (wake[2] >= 0) mq[wake[2]].ret = 1'b1;
            took_issue = issue_in.valid && mq.size() < depth;
            if (consumed)
                void'(mq.pop_front());
            if (took_issue) begin
                mq.push_back(next_op);
                have_op = 0;
                issued++;
                op_count++;
            end
        end
        if (need_full && !saw_full) begin
            error_count++;
            $display("queue never reached full occupancy during %s", name);
        end
        $display("test %s done: %0d checks, %0d errors", name, check_count - checks_before,
                 error_count - errors_before);
    endtask

    initial begin
        void'($urandom(32'h3da9338b));
        reset = 1'b1;
        issue_in = '0;
        addr_in = '0;
        cdb_in = '0;
        retire_in = '0;
        dcache_resp_in = '0;
        mem_return_in = '0;
        exp_cdb = '0;
        op_count = 0;
        check_count = 0;
        error_count = 0;
        for (int t = 0; t < 16; t++)
            pend_valid[t] = 1'b0;
        // outputs stay idle through reset and the first cycle after it
        for (int c = 0; c <= 16; c++) begin
            @(negedge clk);
            if (c == 15) reset = 1'b0;
            #1;
            check_req(dcache_req, '0);
            check_cdb(cdb_out, '0);
            check_bit("stall_dispatch", stall_dispatch, 1'b0);
            check_bit("store_ready", store_ready, 1'b0);
        end
        $display("test reset done: %0d checks, %0d errors", check_count, error_count);
        run_traffic("load_hits", 40, 0, 70, 50, 60, 70, 0);
        run_traffic("load_misses", 40, 0, 0, 60, 60, 70, 0);
        run_traffic("stores", 40, 100, 0, 40, 50, 70, 0);
        run_traffic("order_capacity", 60, 50, 30, 50, 15, 100, 1);
        $display("tests 5, checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog against a queue that never drains
    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns without the tests finishing", timeout_ns);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int period_ns = 40
) (
    output logic clk
);

    // free running, starts low so the first edge is a rising one
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

//--- src/lsq_top.sv
`timescale 1ns/1ns

module lsq_top #(
    parameter int lsq_depth = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::issue_pkt_t  issue_in,
    input  core_pkg::addr_pkt_t   addr_in,
    input  core_pkg::cdb_pkt_t    cdb_in,
    input  core_pkg::retire_pkt_t retire_in,
    input  mem_pkg::dcache_resp_t dcache_resp_in,
    input  mem_pkg::mem_return_t  mem_return_in,
    output mem_pkg::dcache_req_t  dcache_req,
    output core_pkg::cdb_pkt_t    cdb_out,
    output logic                  store_ready,
    output core_pkg::rob_tag_t    store_ready_tag,
    output logic                  stall_dispatch
);

    // queue to tracker
    core_pkg::cdb_pkt_t hit_result;
    logic               miss_alloc_valid;
    mem_pkg::mem_tag_t  miss_alloc_mem_tag;
    core_pkg::rob_tag_t miss_alloc_rob_tag;

    // program order queue and head request
    lsq_queue #(
        .lsq_depth (lsq_depth)
    ) queue_i (
        .clk                (clk),
        .reset              (reset),
        .issue_in           (issue_in),
        .addr_in            (addr_in),
        .cdb_in             (cdb_in),
        .retire_in          (retire_in),
        .dcache_resp_in     (dcache_resp_in),
        .mem_return_in      (mem_return_in),
        .dcache_req         (dcache_req),
        .store_ready        (store_ready),
        .store_ready_tag    (store_ready_tag),
        .stall_dispatch     (stall_dispatch),
        .hit_result         (hit_result),
        .miss_alloc_valid   (miss_alloc_valid),
        .miss_alloc_mem_tag (miss_alloc_mem_tag),
        .miss_alloc_rob_tag (miss_alloc_rob_tag)
    );

    // outstanding misses and the outgoing bus register
    load_tracker tracker_i (
        .clk                (clk),
        .reset              (reset),
        .hit_result         (hit_result),
        .miss_alloc_valid   (miss_alloc_valid),
        .miss_alloc_mem_tag (miss_alloc_mem_tag),
        .miss_alloc_rob_tag (miss_alloc_rob_tag),
        .mem_return_in      (mem_return_in),
        .cdb_out            (cdb_out)
    );

endmodule

//--- src/load_tracker.sv
`timescale 1ns/1ns

module load_tracker (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::cdb_pkt_t   hit_result,
    input  logic                 miss_alloc_valid,
    input  mem_pkg::mem_tag_t    miss_alloc_mem_tag,
    input  core_pkg::rob_tag_t   miss_alloc_rob_tag,
    input  mem_pkg::mem_return_t mem_return_in,
    output core_pkg::cdb_pkt_t   cdb_out
);

    localparam int mem_tags = 2 ** $bits(mem_pkg::mem_tag_t);

    // one slot per nonzero cache tag
    logic [mem_tags-1:1] pending;
    core_pkg::rob_tag_t  miss_rob [1:mem_tags-1];

    logic ret_valid;

    // registered bus result
    logic                      result_valid_q;
    core_pkg::rob_tag_t        result_tag_q;
    logic [core_pkg::xlen-1:0] result_value_q;

    assign ret_valid = (mem_return_in.tag != '0);

    // pending bits and result valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending        <= '0;
            result_valid_q <= 1'b0;
        end else begin
            if (ret_valid) begin
                pending[mem_return_in.tag] <= 1'b0;
            end
            if (miss_alloc_valid) begin
                pending[miss_alloc_mem_tag] <= 1'b1;
            end
            // the queue keeps hits out of return cycles
            result_valid_q <= ret_valid || hit_result.valid;
        end
    end

    // owner tags and result payload
    always_ff @(posedge clk) begin
        if (miss_alloc_valid) begin
            miss_rob[miss_alloc_mem_tag] <= miss_alloc_rob_tag;
        end
        if (ret_valid) begin
            result_tag_q   <= miss_rob[mem_return_in.tag];
            result_value_q <= mem_return_in.data[core_pkg::xlen-1:0];
        end else if (hit_result.valid) begin
            result_tag_q   <= hit_result.tag;
            result_value_q <= hit_result.value;
        end
    end

    assign cdb_out.valid = result_valid_q;
    assign cdb_out.tag   = result_tag_q;
    assign cdb_out.value = result_value_q;

    // cache must not hand out a tag that still has a miss outstanding
    assert property (@(posedge clk) disable iff (reset)
        miss_alloc_valid |-> !pending[miss_alloc_mem_tag]);

    // every return answers a miss we recorded earlier
    assert property (@(posedge clk) disable iff (reset)
        ret_valid |-> pending[mem_return_in.tag]);

endmodule

//--- src/lsq_queue.sv
`timescale 1ns/1ns

module lsq_queue #(
    parameter int lsq_depth = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::issue_pkt_t  issue_in,
    input  core_pkg::addr_pkt_t   addr_in,
    input  core_pkg::cdb_pkt_t    cdb_in,
    input  core_pkg::retire_pkt_t retire_in,
    input  mem_pkg::dcache_resp_t dcache_resp_in,
    input  mem_pkg::mem_return_t  mem_return_in,
    output mem_pkg::dcache_req_t  dcache_req,
    output logic                  store_ready,
    output core_pkg::rob_tag_t    store_ready_tag,
    output logic                  stall_dispatch,
    output core_pkg::cdb_pkt_t    hit_result,
    output logic                  miss_alloc_valid,
    output mem_pkg::mem_tag_t     miss_alloc_mem_tag,
    output core_pkg::rob_tag_t    miss_alloc_rob_tag
);

    localparam int idx_bits = $clog2(lsq_depth);

    // extra msb tells a full ring from an empty one
    typedef logic [idx_bits:0] ptr_t;

    // payload of one queue slot, the ready flags live in separate vectors
    typedef struct packed {
        logic                      is_store;
        core_pkg::rob_tag_t        rob_tag;
        core_pkg::rob_tag_t        data_tag;
        logic [core_pkg::xlen-1:0] addr;
        mem_pkg::mem_data_t        data;
    } lsq_entry_t;

    lsq_entry_t entries [lsq_depth];

    // per slot state
    logic [lsq_depth-1:0] occupied;
    logic [lsq_depth-1:0] addr_valid;
    logic [lsq_depth-1:0] data_valid;
    logic [lsq_depth-1:0] retired;

    ptr_t head_ptr;
    ptr_t tail_ptr;
    logic [idx_bits-1:0] head_idx;
    logic [idx_bits-1:0] tail_idx;
    logic empty;
    logic full;
    logic enq;
    logic pop;

    // associative match results for this cycle
    logic [lsq_depth-1:0] addr_hit;
    logic [lsq_depth-1:0] data_hit;
    logic [lsq_depth-1:0] retire_hit;

    lsq_entry_t head;
    logic load_eligible;
    logic store_eligible;
    logic accepted;

    assign head_idx = head_ptr[idx_bits-1:0];
    assign tail_idx = tail_ptr[idx_bits-1:0];
    assign empty    = (head_ptr == tail_ptr);
    assign full     = (head_idx == tail_idx) && (head_ptr[idx_bits] != tail_ptr[idx_bits]);
    assign stall_dispatch = full;

    // an issue offered while full is simply not taken
    assign enq = issue_in.valid && !full;

    // wakeup matching across all slots
    always_comb begin
        for (int i = 0; i < lsq_depth; i++) begin
            addr_hit[i] = addr_in.valid && occupied[i] && !addr_valid[i]
                          && (entries[i].rob_tag == addr_in.tag);
            // store data comes from whoever produces data_tag
            data_hit[i] = cdb_in.valid && occupied[i] && entries[i].is_store
                          && !data_valid[i] && (entries[i].data_tag == cdb_in.tag);
            retire_hit[i] = retire_in.valid && occupied[i] && entries[i].is_store
                            && (entries[i].rob_tag == retire_in.tag);
        end
    end

    assign head = entries[head_idx];

    // loads stay off the bus while a miss return owns the result slot
    assign load_eligible = !empty && !head.is_store && addr_valid[head_idx]
                           && (mem_return_in.tag == '0);
    assign store_eligible = !empty && head.is_store && addr_valid[head_idx]
                            && data_valid[head_idx] && retired[head_idx];

    assign store_ready     = store_eligible;
    assign store_ready_tag = store_eligible ? head.rob_tag : '0;

    // head request, repeated every cycle until consumed
    always_comb begin
        dcache_req = '0;
        if (load_eligible) begin
            dcache_req.command = mem_pkg::bus_load;
            dcache_req.address = head.addr;
        end else if (store_eligible) begin
            dcache_req.command = mem_pkg::bus_store;
            dcache_req.address = head.addr;
            dcache_req.data    = head.data;
        end
    end

    assign accepted = (dcache_resp_in.accept_tag != '0);

    // a load leaves on a hit or an accepted miss, a store only on accept
    assign pop = (load_eligible && (dcache_resp_in.hit || accepted))
                 || (store_eligible && accepted);

    // hit goes to the tracker, which registers it onto the bus
    assign hit_result.valid = load_eligible && dcache_resp_in.hit;
    assign hit_result.tag   = head.rob_tag;
    assign hit_result.value = dcache_resp_in.hit_data[core_pkg::xlen-1:0];

    // accepted miss, the tracker remembers which load owns the tag
    assign miss_alloc_valid   = load_eligible && !dcache_resp_in.hit && accepted;
    assign miss_alloc_mem_tag = dcache_resp_in.accept_tag;
    assign miss_alloc_rob_tag = head.rob_tag;

    // slot payload, written on enqueue and on wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < lsq_depth; i++) begin
            if (addr_hit[i]) begin
                entries[i].addr <= addr_in.addr;
            end
            // bus value is zero extended to the cache word
            if (data_hit[i]) begin
                entries[i].data <= mem_pkg::mem_data_t'(cdb_in.value);
            end
        end
        if (enq) begin
            entries[tail_idx].is_store <= issue_in.is_store;
            entries[tail_idx].rob_tag  <= issue_in.rob_tag;
            entries[tail_idx].data_tag <= issue_in.data_tag;
        end
    end

    // pointers and ready flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_ptr   <= '0;
            tail_ptr   <= '0;
            occupied   <= '0;
            addr_valid <= '0;
            data_valid <= '0;
            retired    <= '0;
        end else begin
            addr_valid <= addr_valid | addr_hit;
            data_valid <= data_valid | data_hit;
            retired    <= retired | retire_hit;
            if (pop) begin
                occupied[head_idx] <= 1'b0;
                head_ptr           <= head_ptr + ptr_t'(1);
            end
            // new slot starts with nothing collected
            if (enq) begin
                occupied[tail_idx]   <= 1'b1;
                addr_valid[tail_idx] <= 1'b0;
                data_valid[tail_idx] <= 1'b0;
                retired[tail_idx]    <= 1'b0;
                tail_ptr             <= tail_ptr + ptr_t'(1);
            end
        end
    end

    // a new issue must land in a free slot, never on top of a live entry
    assert property (@(posedge clk) disable iff (reset)
        enq |-> !occupied[tail_idx]);

    // the head must hold a live entry when it pops
    assert property (@(posedge clk) disable iff (reset)
        pop |-> occupied[head_idx]);

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

    // commands understood by the data cache
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_t;

    // cache transaction id, zero is reserved for no transaction
    typedef logic [3:0] mem_tag_t;

    // one cache word
    typedef logic [63:0] mem_data_t;

    // request from the queue head, combinational
    typedef struct packed {
        bus_cmd_t                  command;
        logic [core_pkg::xlen-1:0] address;
        mem_data_t                 data;
    } dcache_req_t;

    // answer in the same cycle as the request
    typedef struct packed {
        // nonzero when the cache took the request
        mem_tag_t  accept_tag;
        logic      hit;
        mem_data_t hit_data;
    } dcache_resp_t;

    // miss data coming back later, tag is zero when idle
    typedef struct packed {
        mem_tag_t  tag;
        mem_data_t data;
    } mem_return_t;

endpackage

//--- src/core_pkg.sv
package core_pkg;

    // integer datapath width, also used for effective addresses
    localparam int xlen = 32;

    // reorder buffer slot identifier, 32 in flight
    typedef logic [4:0] rob_tag_t;

    // dispatch of one memory instruction, in program order
    typedef struct packed {
        logic     valid;
        // 1 for a store, 0 for a load
        logic     is_store;
        // identifies the instruction, and its address on the private channel
        rob_tag_t rob_tag;
        // producer of the store value on the common data bus
        rob_tag_t data_tag;
    } issue_pkt_t;

    // private channel from the execute units carrying effective addresses
    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [xlen-1:0] addr;
    } addr_pkt_t;

    // common data bus broadcast
    // same layout for the incoming bus and the load results we drive
    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } cdb_pkt_t;

    // reorder buffer says a memory instruction reached retirement
    // only stores care, loads go without it
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } retire_pkt_t;

endpackage
